// File: design/br_defines.svh
`ifndef BR_DEFINES_SVH
`define BR_DEFINES_SVH

// branch reservation station sizing
`define BR_RS_DEPTH 8
`define BR_RS_PTR_W 3 // log2 of depth

// return address offset for jumps
`define BR_LINK_INC 4

`endif

// File: design/core_types_pkg.sv
`default_nettype none

package core_types_pkg;

    // datapath word, also used for pc and immediates
    typedef logic [31:0] word_t;

    typedef logic [7:0] phys_reg_t; // physical register tag

    // program-order sequence number from rename
    typedef logic [31:0] inst_num_t;

endpackage

`default_nettype wire

// File: design/branch_pkg.sv
`default_nettype none

`include "br_defines.svh"

package branch_pkg;

    // funct3 codes of the conditional branches
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_t;

    typedef logic [`BR_RS_PTR_W-1:0] rs_idx_t; // station slot

endpackage

`default_nettype wire

// File: design/br_operand_capture.sv
`timescale 1ns/1ps
`default_nettype none

module br_operand_capture (
    input  wire core_types_pkg::phys_reg_t src1_tag,
    input  wire core_types_pkg::phys_reg_t src2_tag,
    input  wire core_types_pkg::word_t     src1_data,
    input  wire core_types_pkg::word_t     src2_data,
    input  wire [1:0]                      src_valid,
    input  wire                            alu_valid,
    input  wire                            mul_valid,
    input  wire                            div_valid,
    input  wire                            mem_read,
    input  wire core_types_pkg::phys_reg_t alu_dest,
    input  wire core_types_pkg::phys_reg_t mul_dest,
    input  wire core_types_pkg::phys_reg_t div_dest,
    input  wire core_types_pkg::phys_reg_t mem_dest,
    input  wire core_types_pkg::word_t     alu_data,
    input  wire core_types_pkg::word_t     mul_data,
    input  wire core_types_pkg::word_t     div_data,
    input  wire core_types_pkg::word_t     mem_data,
    output core_types_pkg::word_t          cap1_data,
    output core_types_pkg::word_t          cap2_data,
    output logic                           cap1_valid,
    output logic                           cap2_valid
);
    import core_types_pkg::*;

    // one operand: keep dispatch value or grab a same-cycle result
    function automatic void pick(
        input  phys_reg_t tag,
        input  logic      ready,
        input  word_t     data,
        output logic      cap_v,
        output word_t     cap_d
    );
        cap_v = 1'b1;
        if (ready) begin
            cap_d = data;
        end else if (alu_valid && alu_dest == tag) begin
            cap_d = alu_data;
        end else if (mul_valid && mul_dest == tag) begin
            cap_d = mul_data;
        end else if (div_valid && div_dest == tag) begin
            cap_d = div_data;
        end else if (mem_read && mem_dest == tag) begin
            cap_d = mem_data; // load bus last
        end else begin
            cap_v = 1'b0; // still waiting, wakeup later
            cap_d = data;
        end
    endfunction

    always_comb begin
        pick(src1_tag, src_valid[0], src1_data, cap1_valid, cap1_data);
        pick(src2_tag, src_valid[1], src2_data, cap2_valid, cap2_data);
    end

endmodule

`default_nettype wire

// File: design/br_rs_entry_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "br_defines.svh"

module br_rs_entry_store (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            wr_en,
    input  wire                            issue_en,
    input  wire branch_pkg::rs_idx_t       wr_idx,
    input  wire branch_pkg::rs_idx_t       rd_idx,
    input  wire core_types_pkg::inst_num_t inst_num,
    input  wire core_types_pkg::word_t     pc,
    input  wire core_types_pkg::word_t     imm,
    input  wire core_types_pkg::phys_reg_t rd,
    input  wire                            jump,
    input  wire                            branch,
    input  wire                            pred_taken,
    input  wire                            pred_hit,
    input  wire branch_pkg::br_cond_t      funct3,
    input  wire core_types_pkg::phys_reg_t src1_tag,
    input  wire core_types_pkg::phys_reg_t src2_tag,
    input  wire core_types_pkg::word_t     cap1_data,
    input  wire core_types_pkg::word_t     cap2_data,
    input  wire                            cap1_valid,
    input  wire                            cap2_valid,
    input  wire                            alu_valid,
    input  wire                            mul_valid,
    input  wire                            div_valid,
    input  wire                            mem_read,
    input  wire core_types_pkg::phys_reg_t alu_dest,
    input  wire core_types_pkg::phys_reg_t mul_dest,
    input  wire core_types_pkg::phys_reg_t div_dest,
    input  wire core_types_pkg::phys_reg_t mem_dest,
    input  wire core_types_pkg::word_t     alu_data,
    input  wire core_types_pkg::word_t     mul_data,
    input  wire core_types_pkg::word_t     div_data,
    input  wire core_types_pkg::word_t     mem_data,
    output logic                           head_ready,
    output logic                           issue_valid,
    output core_types_pkg::inst_num_t      iss_inst_num,
    output core_types_pkg::word_t          iss_pc,
    output core_types_pkg::word_t          iss_imm,
    output core_types_pkg::word_t          iss_op1,
    output core_types_pkg::word_t          iss_op2,
    output core_types_pkg::phys_reg_t      iss_rd,
    output logic                           iss_jump,
    output logic                           iss_branch,
    output logic                           iss_pred_taken,
    output logic                           iss_pred_hit,
    output branch_pkg::br_cond_t           iss_funct3
);
    import core_types_pkg::*;
    import branch_pkg::*;

    localparam int DEPTH  = `BR_RS_DEPTH;
    localparam int WORD_W = $bits(word_t);

    inst_num_t inst_num_q [DEPTH];
    word_t     pc_q       [DEPTH];
    word_t     imm_q      [DEPTH];
    phys_reg_t rd_q       [DEPTH];
    br_cond_t  funct3_q   [DEPTH];
    phys_reg_t src1_q     [DEPTH];
    phys_reg_t src2_q     [DEPTH];
    word_t     op1_q      [DEPTH];
    word_t     op2_q      [DEPTH];
    logic [DEPTH-1:0] jump_q, branch_q, taken_q, hit_q;
    logic [DEPTH-1:0] op1_valid_q, op2_valid_q;

    logic [WORD_W:0] wake1 [DEPTH]; // {hit, data}
    logic [WORD_W:0] wake2 [DEPTH];

    // broadcast match for a waiting tag, same bus priority as capture
    function automatic logic [WORD_W:0] snoop(input phys_reg_t tag);
        logic [WORD_W:0] res;
        res = '0;
        if (alu_valid && alu_dest == tag) res = {1'b1, alu_data};
        else if (mul_valid && mul_dest == tag) res = {1'b1, mul_data};
        else if (div_valid && div_dest == tag) res = {1'b1, div_data};
        else if (mem_read && mem_dest == tag) res = {1'b1, mem_data};
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            wake1[i] = snoop(src1_q[i]);
            wake2[i] = snoop(src2_q[i]);
        end
    end

    assign head_ready = op1_valid_q[rd_idx] & op2_valid_q[rd_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            op1_valid_q <= '0;
            op2_valid_q <= '0;
            issue_valid <= 1'b0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (wake1[i][WORD_W]) op1_valid_q[i] <= 1'b1;
                if (wake2[i][WORD_W]) op2_valid_q[i] <= 1'b1;
            end
            if (issue_en) begin // free the head slot
                op1_valid_q[rd_idx] <= 1'b0;
                op2_valid_q[rd_idx] <= 1'b0;
            end
            if (wr_en) begin
                op1_valid_q[wr_idx] <= cap1_valid;
                op2_valid_q[wr_idx] <= cap2_valid;
            end
            issue_valid <= issue_en;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < DEPTH; i++) begin
            if (!op1_valid_q[i] && wake1[i][WORD_W]) op1_q[i] <= wake1[i][WORD_W-1:0];
            if (!op2_valid_q[i] && wake2[i][WORD_W]) op2_q[i] <= wake2[i][WORD_W-1:0];
        end
        if (wr_en) begin
            inst_num_q[wr_idx] <= inst_num;
            pc_q[wr_idx]       <= pc;
            imm_q[wr_idx]      <= imm;
            rd_q[wr_idx]       <= rd;
            funct3_q[wr_idx]   <= funct3;
            src1_q[wr_idx]     <= src1_tag;
            src2_q[wr_idx]     <= src2_tag;
            op1_q[wr_idx]      <= cap1_data;
            op2_q[wr_idx]      <= cap2_data;
            jump_q[wr_idx]     <= jump;
            branch_q[wr_idx]   <= branch;
            taken_q[wr_idx]    <= pred_taken;
            hit_q[wr_idx]      <= pred_hit;
        end
        if (issue_en) begin
            iss_inst_num   <= inst_num_q[rd_idx];
            iss_pc         <= pc_q[rd_idx];
            iss_imm        <= imm_q[rd_idx];
            iss_op1        <= op1_q[rd_idx];
            iss_op2        <= op2_q[rd_idx];
            iss_rd         <= rd_q[rd_idx];
            iss_jump       <= jump_q[rd_idx];
            iss_branch     <= branch_q[rd_idx];
            iss_pred_taken <= taken_q[rd_idx];
            iss_pred_hit   <= hit_q[rd_idx];
            iss_funct3     <= funct3_q[rd_idx];
        end
    end

endmodule

`default_nettype wire

// File: design/br_rs_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "br_defines.svh"

module br_rs_control (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      start,
    input  wire                      head_ready,
    output logic                     wr_en,
    output logic                     issue_en,
    output branch_pkg::rs_idx_t      wr_idx,
    output branch_pkg::rs_idx_t      rd_idx,
    output logic                     rs_full
);
    import branch_pkg::*;

    localparam rs_idx_t LAST = rs_idx_t'(`BR_RS_DEPTH - 1);

    rs_idx_t head_q, tail_q;
    logic [`BR_RS_PTR_W:0] count_q; // 0 .. depth

    assign rs_full  = (count_q == (`BR_RS_PTR_W+1)'(`BR_RS_DEPTH));
    assign wr_en    = start & ~rs_full; // full dispatch is dropped
    assign issue_en = head_ready & (count_q != '0);
    assign wr_idx   = tail_q;
    assign rd_idx   = head_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (wr_en) begin
                tail_q <= (tail_q == LAST) ? '0 : tail_q + 1'b1;
            end
            if (issue_en) begin
                head_q <= (head_q == LAST) ? '0 : head_q + 1'b1;
            end
            // both at once leave the count alone
            case ({wr_en, issue_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/br_resolve.sv
`timescale 1ns/1ps
`default_nettype none

`include "br_defines.svh"

module br_resolve (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            issue_valid,
    input  wire core_types_pkg::inst_num_t iss_inst_num,
    input  wire core_types_pkg::word_t     iss_pc,
    input  wire core_types_pkg::word_t     iss_imm,
    input  wire core_types_pkg::word_t     iss_op1,
    input  wire core_types_pkg::word_t     iss_op2,
    input  wire core_types_pkg::phys_reg_t iss_rd,
    input  wire                            iss_jump,
    input  wire                            iss_branch,
    input  wire                            iss_pred_taken,
    input  wire                            iss_pred_hit,
    input  wire branch_pkg::br_cond_t      iss_funct3,
    output logic                           resolve_valid,
    output core_types_pkg::inst_num_t      resolve_inst_num,
    output logic                           actual_taken,
    output core_types_pkg::word_t          target_pc,
    output core_types_pkg::word_t          link_data,
    output core_types_pkg::phys_reg_t      link_dest,
    output logic                           link_valid,
    output logic                           mispredict
);
    import core_types_pkg::*;
    import branch_pkg::*;

    localparam word_t LINK_INC = word_t'(`BR_LINK_INC);

    logic cond_met;
    logic taken;

    always_comb begin
        case (iss_funct3)
            BR_EQ:   cond_met = (iss_op1 == iss_op2);
            BR_NE:   cond_met = (iss_op1 != iss_op2);
            BR_LT:   cond_met = ($signed(iss_op1) < $signed(iss_op2));
            BR_GE:   cond_met = ($signed(iss_op1) >= $signed(iss_op2));
            BR_LTU:  cond_met = (iss_op1 < iss_op2);
            BR_GEU:  cond_met = (iss_op1 >= iss_op2);
            default: cond_met = 1'b0; // reserved funct3 codes
        endcase
    end

    assign taken = iss_jump | (iss_branch & cond_met);

    always_ff @(posedge clk) begin
        if (reset) begin
            resolve_valid <= 1'b0;
            link_valid    <= 1'b0;
            mispredict    <= 1'b0;
        end else begin
            resolve_valid <= issue_valid;
            link_valid    <= issue_valid & iss_jump;
            // wrong direction, or taken without a btb hit
            mispredict    <= issue_valid & ((taken != iss_pred_taken) | (taken & ~iss_pred_hit));
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            resolve_inst_num <= iss_inst_num;
            actual_taken     <= taken;
            target_pc        <= iss_pc + iss_imm;
            link_data        <= iss_pc + LINK_INC;
            link_dest        <= iss_rd;
        end
    end

endmodule

`default_nettype wire

// File: design/br_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module br_unit_top (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            start,
    input  wire core_types_pkg::inst_num_t inst_num,
    input  wire core_types_pkg::word_t     pc,
    input  wire core_types_pkg::phys_reg_t rd,
    input  wire                            jump,
    input  wire                            branch,
    input  wire branch_pkg::br_cond_t      funct3,
    input  wire core_types_pkg::word_t     imm,
    input  wire core_types_pkg::phys_reg_t src1_tag,
    input  wire core_types_pkg::phys_reg_t src2_tag,
    input  wire core_types_pkg::word_t     src1_data,
    input  wire core_types_pkg::word_t     src2_data,
    input  wire [1:0]                      src_valid,
    input  wire                            pred_taken,
    input  wire                            pred_hit,
    input  wire                            alu_valid,
    input  wire core_types_pkg::phys_reg_t alu_dest,
    input  wire core_types_pkg::word_t     alu_data,
    input  wire                            mul_valid,
    input  wire core_types_pkg::phys_reg_t mul_dest,
    input  wire core_types_pkg::word_t     mul_data,
    input  wire                            div_valid,
    input  wire core_types_pkg::phys_reg_t div_dest,
    input  wire core_types_pkg::word_t     div_data,
    input  wire                            mem_read,
    input  wire core_types_pkg::phys_reg_t mem_dest,
    input  wire core_types_pkg::word_t     mem_data,
    output wire                            rs_full,
    output wire                            issue_valid,
    output wire                            resolve_valid,
    output wire core_types_pkg::inst_num_t resolve_inst_num,
    output wire                            actual_taken,
    output wire core_types_pkg::word_t     target_pc,
    output wire core_types_pkg::word_t     link_data,
    output wire core_types_pkg::phys_reg_t link_dest,
    output wire                            link_valid,
    output wire                            mispredict
);
    import core_types_pkg::*;
    import branch_pkg::*;

    wire word_t     cap1_data, cap2_data;
    wire            cap1_valid, cap2_valid;
    wire            wr_en, issue_en, head_ready;
    wire rs_idx_t   wr_idx, rd_idx;

    // issue stage payload
    wire inst_num_t iss_inst_num;
    wire word_t     iss_pc, iss_imm, iss_op1, iss_op2;
    wire phys_reg_t iss_rd;
    wire            iss_jump, iss_branch, iss_pred_taken, iss_pred_hit;
    wire br_cond_t  iss_funct3;

    br_operand_capture br_operand_capture_inst (.*);

    br_rs_control br_rs_control_inst (.*);

    br_rs_entry_store br_rs_entry_store_inst (.*);

    br_resolve br_resolve_inst (.*);

endmodule

`default_nettype wire

// File: verification/br_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module br_unit_tb;
    import core_types_pkg::*;
    import branch_pkg::*;

    // expected resolve result of one accepted dispatch
    typedef struct packed {
        inst_num_t num;
        logic      taken;
        word_t     target;
        word_t     link;
        phys_reg_t rd;
        logic      jmp;
        logic      misp;
    } exp_t;

    logic       clk, reset, start, jump, branch, pred_taken, pred_hit;
    logic       alu_valid, mul_valid, div_valid, mem_read;
    logic [1:0] src_valid;
    inst_num_t  inst_num;
    word_t      pc, imm, src1_data, src2_data, alu_data, mul_data, div_data, mem_data;
    phys_reg_t  rd, src1_tag, src2_tag, alu_dest, mul_dest, div_dest, mem_dest;
    br_cond_t   funct3;
    wire        rs_full, issue_valid, resolve_valid, actual_taken, link_valid, mispredict;
    wire inst_num_t resolve_inst_num;
    wire word_t     target_pc, link_data;
    wire phys_reg_t link_dest;

    exp_t      exp_q[$];
    word_t     tag_data[256]; // value every broadcast of a tag carries
    int        resolved;
    inst_num_t next_num;
    br_cond_t  conds[6] = '{BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU};
    word_t     edges[6] = '{32'h0, 32'h1, 32'h7fff_ffff,
                            32'h8000_0000, 32'hffff_ffff, 32'h8000_0001};

    br_unit_top br_unit_top_inst (.*);

    always #50 clk = ~clk;

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] want);
        $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, want);
        abort_run();
    endtask

    task automatic plain_error(input string what);
        $display("ERROR: %s", what);
        abort_run();
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want) else value_error(name, got, want);
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        assert (got === want) else value_error(name, {31'h0, got}, {31'h0, want});
    endtask

    function automatic logic cond_holds(input br_cond_t f3, input word_t a, input word_t b);
        logic signed [31:0] sa, sb;
        sa = a;
        sb = b;
        case (f3)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return sa < sb;
            BR_GE:   return !(sa < sb);
            BR_LTU:  return a < b;
            default: return !(a < b); // geu
        endcase
    endfunction

    task automatic fields(input br_cond_t f3, input logic j, input word_t p, input word_t im,
                          input logic pt, input logic ph);
        funct3 = f3;
        jump = j;
        branch = !j;
        pc = p;
        imm = im;
        pred_taken = pt;
        pred_hit = ph;
    endtask

    task automatic operands(input logic r1, input phys_reg_t t1, input word_t d1,
                            input logic r2, input phys_reg_t t2, input word_t d2);
        src_valid = {r2, r1};
        src1_tag = t1;
        src1_data = d1;
        src2_tag = t2;
        src2_data = d2;
    endtask

    task automatic put_on_bus(input int bus, input phys_reg_t tag);
        case (bus)
            0:       {alu_valid, alu_dest, alu_data} = {1'b1, tag, tag_data[tag]};
            1:       {mul_valid, mul_dest, mul_data} = {1'b1, tag, tag_data[tag]};
            2:       {div_valid, div_dest, div_data} = {1'b1, tag, tag_data[tag]};
            default: {mem_read, mem_dest, mem_data} = {1'b1, tag, tag_data[tag]};
        endcase
    endtask

    // raise start and record the expected outcome of an accepted dispatch
    task automatic send(input logic accept);
        exp_t  e;
        word_t a, b;
        a = src_valid[0] ? src1_data : tag_data[src1_tag];
        b = src_valid[1] ? src2_data : tag_data[src2_tag];
        inst_num = next_num;
        rd = next_num[7:0] ^ 8'h3c;
        e.num = next_num;
        e.taken = jump || (branch && cond_holds(funct3, a, b));
        e.target = pc + imm;
        e.link = pc + 32'd4;
        e.rd = rd;
        e.jmp = jump;
        e.misp = (e.taken != pred_taken) || (e.taken && !pred_hit);
        start = 1'b1;
        check_bit("rs_full", rs_full, !accept);
        if (accept) exp_q.push_back(e);
        next_num++;
    endtask

    task automatic next_slot();
        @(posedge clk);
        #5;
        start = 1'b0;
        {alu_valid, mul_valid, div_valid, mem_read} = 4'b0;
    endtask

    // empty station: issue after one edge, resolve after two
    task automatic expect_latency();
        int lat;
        lat = 0;
        next_slot();
        do begin
            @(posedge clk);
            lat++;
            @(negedge clk);
            if (lat == 1) check_bit("issue_valid", issue_valid, 1'b1);
        end while (!resolve_valid && lat < 8);
        if (!resolve_valid) plain_error("timed out waiting for resolve_valid");
        check_word("resolve latency", lat, 2);
        next_slot();
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            if (cycles == 300) begin
                plain_error("timed out waiting for outstanding branches to resolve");
            end
            next_slot();
            cycles++;
        end
    endtask

    always @(negedge clk) begin : result_monitor
        exp_t e;
        if (!reset && resolve_valid) begin
            if (exp_q.size() == 0) begin
                plain_error("resolve_valid with no dispatch outstanding");
            end else begin
                e = exp_q.pop_front();
                check_word("resolve_inst_num", resolve_inst_num, e.num);
                check_bit("actual_taken", actual_taken, e.taken);
                check_word("target_pc", target_pc, e.target);
                check_bit("mispredict", mispredict, e.misp);
                check_bit("link_valid", link_valid, e.jmp);
                if (e.jmp) begin
                    check_word("link_data", link_data, e.link);
                    check_word("link_dest", {24'h0, link_dest}, {24'h0, e.rd});
                end
                resolved++;
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset)
                     (mispredict || link_valid) |-> resolve_valid)
        else plain_error("mispredict or link_valid high without resolve_valid");

    initial begin : stimulus
        int first;
        void'($urandom(33));
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        inst_num = '0;
        rd = '0;
        fields(BR_EQ, 1'b0, '0, '0, 1'b0, 1'b0);
        operands(1'b1, '0, '0, 1'b1, '0, '0);
        {alu_valid, mul_valid, div_valid, mem_read} = 4'b0;
        {alu_dest, mul_dest, div_dest, mem_dest} = '0;
        {alu_data, mul_data, div_data, mem_data} = '0;
        for (int t = 0; t < 256; t++) tag_data[t] = $urandom();
        resolved = 0;
        next_num = 1;
        repeat (10) @(posedge clk);
        #5;
        reset = 1'b0;
        check_bit("issue_valid", issue_valid, 1'b0);
        check_bit("resolve_valid", resolve_valid, 1'b0);
        check_bit("mispredict", mispredict, 1'b0);
        check_bit("rs_full", rs_full, 1'b0);

        // every condition against every edge pair, operands ready
        for (int c = 0; c < 6; c++)
            for (int i = 0; i < 6; i++)
                for (int j = 0; j < 6; j++) begin
                    fields(conds[c], 1'b0, 32'h0000_1000, edges[j], i[0], j[0]);
                    operands(1'b1, 8'd1, edges[i], 1'b1, 8'd2, edges[j]);
                    send(1'b1);
                    expect_latency();
                end

        // both operands captured from two buses in the dispatch cycle
        for (int t = 0; t < 4; t++) tag_data[20 + t] = edges[t + 2];
        for (int c = 0; c < 6; c++) begin
            fields(conds[c], 1'b0, 32'h0000_1800, 32'h40, 1'b1, 1'b1);
            operands(1'b0, phys_reg_t'(20 + c % 4), '0, 1'b0, phys_reg_t'(20 + (c + 1) % 4), '0);
            put_on_bus(c % 4, phys_reg_t'(20 + c % 4));
            put_on_bus((c + 1) % 4, phys_reg_t'(20 + (c + 1) % 4));
            send(1'b1);
            expect_latency();
        end

        // not-taken branch, taken branch, jump, each with all prediction bits
        for (int k = 0; k < 12; k++) begin
            fields(BR_EQ, k >= 8, 32'h0000_2000 + 32'(k * 4), 32'hffff_fff0, k[0], k[1]);
            operands(1'b1, 8'd0, 32'd5, 1'b1, 8'd0, (k >= 4 && k < 8) ? 32'd5 : 32'd6);
            send(1'b1);
            expect_latency();
        end

        // waiting entries, woken in reverse order on different buses
        for (int k = 0; k < 4; k++) begin
            fields(conds[k], 1'b0, 32'h0000_3000 + 32'(k * 8), 32'h100, 1'b1, 1'b1);
            operands(1'b0, phys_reg_t'(40 + k), '0, k[0], phys_reg_t'(50 + k), 32'h7fff_ffff);
            send(1'b1);
            next_slot();
        end
        for (int k = 3; k >= 0; k--) begin
            put_on_bus(k, phys_reg_t'(40 + k));
            put_on_bus((k + 1) % 4, phys_reg_t'(50 + k));
            next_slot();
        end
        wait_drained();

        // fill all slots, then a ninth dispatch that must be dropped
        first = resolved;
        for (int k = 0; k < 9; k++) begin
            fields(conds[k % 6], 1'b0, 32'h0000_4000 + 32'(k * 4), 32'h20, 1'b0, 1'b1);
            operands(1'b0, phys_reg_t'(60 + k), '0, 1'b1, '0, 32'h8000_0000);
            send(k < 8);
            next_slot();
        end
        for (int k = 0; k < 5; k++) begin
            put_on_bus(0, phys_reg_t'(60 + 2 * k));
            put_on_bus(2, phys_reg_t'(61 + 2 * k));
            next_slot();
        end
        wait_drained();
        repeat (10) next_slot();
        check_word("results after back-pressure", resolved - first, 8);

        // random dispatches and broadcasts over a small tag pool
        for (int k = 0; k < 80; k++) begin
            if ($urandom() % 2 == 0 && exp_q.size() < 8) begin // station has room
                fields(conds[$urandom() % 6], ($urandom() % 4) == 0, $urandom(), $urandom(),
                       1'($urandom()), 1'($urandom()));
                operands(1'($urandom()), phys_reg_t'(100 + $urandom() % 8), $urandom(),
                         1'($urandom()), phys_reg_t'(100 + $urandom() % 8), $urandom());
                send(1'b1);
            end
            if ($urandom() % 3 == 0) begin
                put_on_bus(int'($urandom() % 4), phys_reg_t'(100 + $urandom() % 8));
            end
            next_slot();
        end
        for (int t = 100; t < 108; t++) begin
            put_on_bus(t % 4, phys_reg_t'(t));
            next_slot();
        end
        wait_drained();
        repeat (5) next_slot();

        if (exp_q.size() != 0) begin
            plain_error("results left outstanding at end of run");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+design
design/core_types_pkg.sv
design/branch_pkg.sv
design/br_operand_capture.sv
design/br_rs_entry_store.sv
design/br_rs_control.sv
design/br_resolve.sv
design/br_unit_top.sv
verification/br_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the branch unit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module br_unit_tb -o br_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/br_unit_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx ">>> PASS"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
